// File: Makefile
# Verilator build and run for the GPIO control block testbench

VERILATOR ?= verilator
TOP       ?= tb_mprj_ctrl
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= ALL CHECKS PASSED

SOURCES := $(wildcard logic/*.sv logic/*.svh test/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: logic/mprj_ctrl_cfg.svh
`ifndef MPRJ_CTRL_CFG_SVH
`define MPRJ_CTRL_CFG_SVH

// Slave window is 256 bytes, matched on the upper 24 address bits
`define MPRJ_BASE_ADR    24'h2300_00

// Byte offsets inside the window
`define MPRJ_DATA_OFS    8'h00     // GPIO data word 0, word k at +4k
`define MPRJ_XFER_OFS    8'h0C     // Serial load start and busy flag
`define MPRJ_IO_OFS      8'h20     // Pad 0 control word, pad i at +4i

// Pad ring size, 1 to 56 pads fit the window
`define MPRJ_IO_PADS     38

// Data words needed to cover all pads
`define MPRJ_IO_WORDS    ((`MPRJ_IO_PADS + 31) / 32)

// Width of one pad control word
`define MPRJ_CTRL_BITS   13

// Control word reset values
`define MPRJ_CTRL_BIDIR  13'h1803  // Pads 0 and 1, JTAG and SDO
`define MPRJ_CTRL_INPUT  13'h0403  // All other pads

`endif

// File: logic/mprj_ctrl_pkg.sv
`include "mprj_ctrl_cfg.svh"

package mprj_ctrl_pkg;

    // Field layout of one pad control word, MSB first
    typedef struct packed {
        logic [2:0] dm;             // Drive mode
        logic       vtrip_sel;
        logic       slow_sel;
        logic       analog_pol;
        logic       analog_sel;
        logic       analog_en;
        logic       ib_sel;
        logic       inp_dis;        // Bit 3, also enables mgmt output
        logic       hold_override;
        logic       oeb;            // Bit 1, active low output enable
        logic       mgmt_en;
    } pad_ctrl_fields_t;

    // Raw view for bus access and shifting, field view for decoding
    typedef union packed {
        logic [`MPRJ_CTRL_BITS-1:0] raw;
        pad_ctrl_fields_t           f;
    } pad_ctrl_u;

endpackage

// File: logic/mprj_ctrl_wb.sv
`timescale 1ns/10ps
`include "mprj_ctrl_cfg.svh"

module mprj_ctrl_wb (
    input  logic                     clk,
    input  logic                     resetn,

    // Wishbone slave
    input  logic [31:0]              wb_adr_i,
    input  logic [31:0]              wb_dat_i,
    input  logic [3:0]               wb_sel_i,
    input  logic                     wb_we_i,
    input  logic                     wb_cyc_i,
    input  logic                     wb_stb_i,
    output logic [31:0]              wb_dat_o,
    output logic                     wb_ack_o,

    // Pad configuration chain
    output logic                     serial_clock_o,
    output logic                     serial_resetn_o,
    output logic                     serial_data_o,

    // OEB state of the JTAG and SDO pads for the core
    output logic                     sdo_oenb_state_o,
    output logic                     jtag_oenb_state_o,

    input  logic [`MPRJ_IO_PADS-1:0] mgmt_gpio_in_i,
    output logic [`MPRJ_IO_PADS-1:0] mgmt_gpio_out_o,
    output logic [`MPRJ_IO_PADS-1:0] mgmt_gpio_oe_o
);
    import mprj_ctrl_pkg::*;

    logic      valid;
    logic      wen;
    logic      xfer_start;
    logic      busy;
    logic [5:0] pad_sel;
    pad_ctrl_u pad_word;

    assign valid = wb_stb_i && wb_cyc_i;
    assign wen   = wb_we_i && wb_sel_i[0];   // Control words need the low byte lane

    mprj_regs u_regs (
        .clk               (clk),
        .resetn            (resetn),
        .adr_i             (wb_adr_i),
        .wdata_i           (wb_dat_i),
        .valid_i           (valid),
        .wen_i             (wen),
        .rdata_o           (wb_dat_o),
        .ack_o             (wb_ack_o),
        .xfer_start_o      (xfer_start),
        .busy_i            (busy),
        .pad_sel_i         (pad_sel),
        .pad_word_o        (pad_word),
        .gpio_in_i         (mgmt_gpio_in_i),
        .gpio_out_o        (mgmt_gpio_out_o),
        .gpio_oe_o         (mgmt_gpio_oe_o),
        .sdo_oenb_state_o  (sdo_oenb_state_o),
        .jtag_oenb_state_o (jtag_oenb_state_o)
    );

    serial_loader u_loader (
        .clk             (clk),
        .resetn          (resetn),
        .xfer_start_i    (xfer_start),
        .busy_o          (busy),
        .pad_sel_o       (pad_sel),
        .pad_word_i      (pad_word),
        .serial_clock_o  (serial_clock_o),
        .serial_resetn_o (serial_resetn_o),
        .serial_data_o   (serial_data_o)
    );

endmodule

// File: logic/mprj_regs.sv
`timescale 1ns/10ps
`include "mprj_ctrl_cfg.svh"

module mprj_regs (
    input  logic                     clk,
    input  logic                     resetn,

    input  logic [31:0]              adr_i,
    input  logic [31:0]              wdata_i,
    input  logic                     valid_i,
    input  logic                     wen_i,
    output logic [31:0]              rdata_o,
    output logic                     ack_o,

    output logic                     xfer_start_o,
    input  logic                     busy_i,
    input  logic [5:0]               pad_sel_i,
    output mprj_ctrl_pkg::pad_ctrl_u pad_word_o,

    input  logic [`MPRJ_IO_PADS-1:0] gpio_in_i,
    output logic [`MPRJ_IO_PADS-1:0] gpio_out_o,
    output logic [`MPRJ_IO_PADS-1:0] gpio_oe_o,
    output logic                     sdo_oenb_state_o,
    output logic                     jtag_oenb_state_o
);
    import mprj_ctrl_pkg::*;

    localparam int PADS      = `MPRJ_IO_PADS;
    localparam int WORDS     = `MPRJ_IO_WORDS;
    localparam int CTRL_BITS = `MPRJ_CTRL_BITS;
    localparam int DATA_WORD = `MPRJ_DATA_OFS >> 2;
    localparam int IO_WORD   = `MPRJ_IO_OFS >> 2;

    logic [PADS-1:0] gpio_q;               // Output data, one bit per pad
    pad_ctrl_u       pad_ctrl_q [PADS];
    logic            ack_q;
    logic            xfer_start_q;
    logic [31:0]     rdata_q;
    logic [31:0]     rd_word;

    logic            base_hit;
    logic            accept;
    logic [5:0]      word_idx;
    logic [5:0]      data_idx;
    logic [5:0]      pad_idx;
    logic            aligned;
    logic            data_hit;
    logic            xfer_hit;
    logic            io_hit;

    // Address decode
    assign base_hit = adr_i[31:8] == `MPRJ_BASE_ADR;
    assign accept   = valid_i && !ack_q && base_hit;   // One access per strobe
    assign word_idx = adr_i[7:2];
    assign aligned  = adr_i[1:0] == 2'b00;
    assign data_idx = word_idx - 6'(DATA_WORD);
    assign pad_idx  = word_idx - 6'(IO_WORD);

    assign data_hit = aligned && int'(word_idx) >= DATA_WORD
                      && int'(word_idx) < DATA_WORD + WORDS;
    assign xfer_hit = adr_i[7:0] == `MPRJ_XFER_OFS;
    assign io_hit   = aligned && int'(word_idx) >= IO_WORD
                      && int'(word_idx) < IO_WORD + PADS;

    // Readback selection, zero for unmapped offsets
    always_comb begin
        rd_word = '0;
        if (data_hit) begin
            for (int p = 0; p < PADS; p++) begin
                if (p / 32 == int'(data_idx)) begin
                    rd_word[p % 32] = gpio_in_i[p];
                end
            end
        end else if (xfer_hit) begin
            rd_word[0] = busy_i;
        end else if (io_hit) begin
            rd_word[CTRL_BITS-1:0] = pad_ctrl_q[pad_idx].raw;
        end
    end

    // Ack and load start strobe
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            ack_q        <= 1'b0;
            xfer_start_q <= 1'b0;
        end else begin
            ack_q        <= accept;
            xfer_start_q <= accept && wen_i && xfer_hit && wdata_i[0];
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= rd_word;   // Valid together with ack
        end
    end

    // GPIO output data
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            gpio_q <= '0;
        end else if (accept && wen_i && data_hit) begin
            for (int p = 0; p < PADS; p++) begin
                if (p / 32 == int'(data_idx)) begin
                    gpio_q[p] <= wdata_i[p % 32];
                end
            end
        end
    end

    // Pad control words
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int p = 0; p < PADS; p++) begin
                pad_ctrl_q[p].raw <= (p < 2) ? `MPRJ_CTRL_BIDIR : `MPRJ_CTRL_INPUT;
            end
        end else if (accept && wen_i && io_hit) begin
            pad_ctrl_q[pad_idx].raw <= wdata_i[CTRL_BITS-1:0];
        end
    end

    // Management drives a pad only where its input is disabled
    always_comb begin
        for (int p = 0; p < PADS; p++) begin
            gpio_oe_o[p]  = pad_ctrl_q[p].f.inp_dis;
            gpio_out_o[p] = gpio_q[p] & pad_ctrl_q[p].f.inp_dis;
        end
    end

    assign jtag_oenb_state_o = pad_ctrl_q[0].f.oeb;

    // A single pad ring has no SDO pad, report it as not driven
    generate
        if (PADS > 1) begin : g_sdo_pad
            assign sdo_oenb_state_o = pad_ctrl_q[1].f.oeb;
        end else begin : g_no_sdo_pad
            assign sdo_oenb_state_o = 1'b1;
        end
    endgenerate

    assign pad_word_o   = pad_ctrl_q[pad_sel_i];   // Word for the loader
    assign rdata_o      = rdata_q;
    assign ack_o        = ack_q;
    assign xfer_start_o = xfer_start_q;

endmodule

// File: logic/serial_loader.sv
`timescale 1ns/10ps
`include "mprj_ctrl_cfg.svh"

module serial_loader (
    input  logic                     clk,
    input  logic                     resetn,

    input  logic                     xfer_start_i,
    output logic                     busy_o,
    output logic [5:0]               pad_sel_o,
    input  mprj_ctrl_pkg::pad_ctrl_u pad_word_i,

    output logic                     serial_clock_o,
    output logic                     serial_resetn_o,
    output logic                     serial_data_o
);
    localparam int CTRL_BITS = `MPRJ_CTRL_BITS;
    localparam logic [5:0] LAST_PAD = 6'(`MPRJ_IO_PADS - 1);

    // FSM encoding
    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_START = 2'd1;
    localparam logic [1:0] ST_SHIFT = 2'd2;
    localparam logic [1:0] ST_LOAD  = 2'd3;

    logic [1:0]           state_q;
    logic [5:0]           pad_q;      // Pad being loaded, counts down
    logic [3:0]           cnt_q;      // Bit index in SHIFT, step in LOAD
    logic [CTRL_BITS-1:0] stage_q;    // Staging word, MSB goes out first
    logic                 sclk_q;
    logic                 sresetn_q;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q   <= ST_IDLE;
            pad_q     <= LAST_PAD;
            cnt_q     <= '0;
            stage_q   <= '0;
            sclk_q    <= 1'b0;
            sresetn_q <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    sclk_q    <= 1'b0;
                    sresetn_q <= 1'b1;
                    pad_q     <= LAST_PAD;   // Last pad goes in first
                    if (xfer_start_i) begin
                        state_q <= ST_START;
                    end
                end

                ST_START: begin
                    stage_q <= pad_word_i.raw;
                    cnt_q   <= '0;
                    state_q <= ST_SHIFT;
                end

                ST_SHIFT: begin
                    if (!sclk_q) begin
                        sclk_q <= 1'b1;          // Chain samples on this edge
                    end else if (cnt_q == 4'(CTRL_BITS - 1)) begin
                        cnt_q <= '0;
                        if (pad_q == '0) begin
                            state_q <= ST_LOAD;  // Clock stays high into LOAD
                        end else begin
                            sclk_q  <= 1'b0;
                            pad_q   <= pad_q - 6'd1;
                            state_q <= ST_START;
                        end
                    end else begin
                        sclk_q  <= 1'b0;
                        stage_q <= {stage_q[CTRL_BITS-2:0], 1'b0};
                        cnt_q   <= cnt_q + 4'd1;
                    end
                end

                ST_LOAD: begin
                    // Reset pulse while the clock is high latches the chain
                    cnt_q <= cnt_q + 4'd1;
                    case (cnt_q)
                        4'd0: sresetn_q <= 1'b0;
                        4'd1: sresetn_q <= 1'b1;
                        default: begin
                            sclk_q  <= 1'b0;
                            cnt_q   <= '0;
                            state_q <= ST_IDLE;
                        end
                    endcase
                end

                default: state_q <= ST_IDLE;
            endcase
        end
    end

    assign busy_o          = state_q != ST_IDLE;
    assign pad_sel_o       = pad_q;
    assign serial_clock_o  = sclk_q;
    assign serial_resetn_o = sresetn_q;
    assign serial_data_o   = stage_q[CTRL_BITS-1];

endmodule

// File: tb.f
+incdir+logic
logic/mprj_ctrl_pkg.sv
logic/serial_loader.sv
logic/mprj_regs.sv
logic/mprj_ctrl_wb.sv
test/pad_chain_model.sv
test/tb_mprj_ctrl.sv

// File: test/pad_chain_model.sv
`timescale 1ns/10ps
`include "mprj_ctrl_cfg.svh"

module pad_chain_model (
    input  logic                                          serial_clock_i,
    input  logic                                          serial_resetn_i,
    input  logic                                          serial_data_i,
    output logic [`MPRJ_IO_PADS*`MPRJ_CTRL_BITS-1:0]      latched_o
);
    localparam int CHAIN_BITS = `MPRJ_IO_PADS * `MPRJ_CTRL_BITS;

    // External shift chain and its load latch
    logic [CHAIN_BITS-1:0] chain_q = '0;
    logic [CHAIN_BITS-1:0] latch_q = '0;

    // First bit in travels to the top, so pad i ends up at bits 13i and up
    always @(posedge serial_clock_i) begin
        chain_q <= {chain_q[CHAIN_BITS-2:0], serial_data_i};
    end

    // Load strobe is a reset pulse while the chain clock is held high
    always @(negedge serial_resetn_i) begin
        if (serial_clock_i === 1'b1) begin
            latch_q <= chain_q;
        end
    end

    assign latched_o = latch_q;

endmodule

// File: test/tb_mprj_ctrl.sv
`timescale 1ns/10ps
`include "mprj_ctrl_cfg.svh"

module tb_mprj_ctrl;
    localparam int PADS  = `MPRJ_IO_PADS;
    localparam int WORDS = `MPRJ_IO_WORDS;
    localparam int CBITS = `MPRJ_CTRL_BITS;

    // Every access ends within 4 cycles and each load takes 1 + 27 per pad + 3
    localparam int LOAD_CYCLES = 1 + PADS * 27 + 3;
    localparam int ACCESSES    = 5 * PADS + 24;
    localparam int MAX_CYCLES  = 2 * (ACCESSES * 4 + 2 * LOAD_CYCLES);

    localparam logic [31:0] BASE     = {`MPRJ_BASE_ADR, 8'h00};
    localparam logic [31:0] XFER_ADR = BASE + 32'(`MPRJ_XFER_OFS);

    logic              clk;
    logic              resetn;
    logic [31:0]       wb_adr;
    logic [31:0]       wb_dat_w;
    logic [3:0]        wb_sel;
    logic              wb_we;
    logic              wb_cyc;
    logic              wb_stb;
    logic [31:0]       wb_dat_r;
    logic              wb_ack;
    logic              serial_clock;
    logic              serial_resetn;
    logic              serial_data;
    logic              sdo_oenb;
    logic              jtag_oenb;
    logic [PADS-1:0]   mgmt_gpio_in;
    logic [PADS-1:0]   mgmt_gpio_out;
    logic [PADS-1:0]   mgmt_gpio_oe;
    logic [PADS*CBITS-1:0] chain_latched;

    integer            seed = 32'h2358_ea87;
    int                value_errors;
    int                other_errors;
    int                cycles;
    logic [CBITS-1:0]  ctrl_model [PADS];   // Expected control words
    logic [PADS-1:0]   gpio_model;          // Expected output data

    mprj_ctrl_wb dut (
        .clk (clk), .resetn (resetn),
        .wb_adr_i (wb_adr), .wb_dat_i (wb_dat_w), .wb_sel_i (wb_sel),
        .wb_we_i (wb_we), .wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb),
        .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack),
        .serial_clock_o (serial_clock), .serial_resetn_o (serial_resetn),
        .serial_data_o (serial_data),
        .sdo_oenb_state_o (sdo_oenb), .jtag_oenb_state_o (jtag_oenb),
        .mgmt_gpio_in_i (mgmt_gpio_in), .mgmt_gpio_out_o (mgmt_gpio_out),
        .mgmt_gpio_oe_o (mgmt_gpio_oe)
    );

    pad_chain_model u_chain (
        .serial_clock_i  (serial_clock),
        .serial_resetn_i (serial_resetn),
        .serial_data_i   (serial_data),
        .latched_o       (chain_latched)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ack_pulse: assert property (@(posedge clk) disable iff (!resetn) wb_ack |=> !wb_ack)
        else begin
            other_errors++;
            $display("Ack stayed high for more than one cycle at %0t", $time);
        end

    load_edge: assert property (@(posedge clk) disable iff (!resetn)
                                $fell(serial_resetn) |-> serial_clock)
        else begin
            other_errors++;
            $display("Pad chain load pulse fell while its clock was low at %0t", $time);
        end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // Starts on a falling edge and returns on the falling edge that shows ack
    task automatic wb_write(input logic [31:0] adr, input logic [31:0] data,
                            input logic [3:0] sel);
        wb_adr   = adr;
        wb_dat_w = data;
        wb_sel   = sel;
        wb_we    = 1'b1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        do @(negedge clk); while (!wb_ack);
        wb_stb = 1'b0;
        wb_cyc = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [31:0] adr, output logic [31:0] data);
        wb_adr = adr;
        wb_sel = 4'hF;
        wb_we  = 1'b0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        do @(negedge clk); while (!wb_ack);
        data   = wb_dat_r;   // Registered data comes with ack
        wb_stb = 1'b0;
        wb_cyc = 1'b0;
    endtask

    task automatic read_expect(input string name, input logic [31:0] adr,
                               input logic [31:0] exp);
        logic [31:0] data;
        wb_read(adr, data);
        check_value(name, 64'(data), 64'(exp));
    endtask

    task automatic expect_no_ack(input logic [31:0] adr);
        wb_adr = adr;
        wb_we  = 1'b0;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        repeat (4) begin
            @(negedge clk);
            assert (!wb_ack) else begin
                other_errors++;
                $display("Access to 0x%0h outside the window was acknowledged", adr);
            end
        end
        wb_stb = 1'b0;
        wb_cyc = 1'b0;
    endtask

    function automatic logic [31:0] ctrl_adr(input int pad);
        return BASE + 32'(`MPRJ_IO_OFS) + 32'(4 * pad);
    endfunction

    function automatic logic [31:0] data_adr(input int word);
        return BASE + 32'(`MPRJ_DATA_OFS) + 32'(4 * word);
    endfunction

    function automatic logic [PADS-1:0] inp_dis_bits();
        logic [PADS-1:0] bits;
        for (int p = 0; p < PADS; p++) begin
            bits[p] = ctrl_model[p][3];   // inp_dis
        end
        return bits;
    endfunction

    task automatic write_ctrl(input int pad, input logic [31:0] value);
        wb_write(ctrl_adr(pad), value, 4'hF);
        ctrl_model[pad] = value[CBITS-1:0];   // Upper bits are dropped
    endtask

    // Random words, start a load, poll busy, then compare the chain latch
    task automatic run_load();
        logic [31:0] data;
        for (int p = 0; p < PADS; p++) write_ctrl(p, 32'($random(seed)));
        wb_write(XFER_ADR, 32'h1, 4'hF);
        wb_read(XFER_ADR, data);
        check_value("xfer busy after start", 64'(data), 64'h1);
        while (data[0]) wb_read(XFER_ADR, data);
        check_value("xfer after load", 64'(data), 64'h0);
        for (int p = 0; p < PADS; p++) begin
            check_value($sformatf("chain pad %0d", p),
                        64'(chain_latched[p*CBITS +: CBITS]), 64'(ctrl_model[p]));
        end
    endtask

    initial begin
        logic [31:0] data;
        logic [63:0] out_words;
        clk = 1'b0;
        resetn = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = '0;
        wb_we = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        mgmt_gpio_in = '0;
        value_errors = 0;
        other_errors = 0;
        cycles = 0;
        gpio_model = '0;
        for (int p = 0; p < PADS; p++) begin
            ctrl_model[p] = (p < 2) ? `MPRJ_CTRL_BIDIR : `MPRJ_CTRL_INPUT;
        end
        repeat (4) @(negedge clk);
        resetn = 1'b1;

        // Reset values
        check_value("jtag_oenb_state_o", 64'(jtag_oenb), 64'h1);
        check_value("sdo_oenb_state_o", 64'(sdo_oenb), 64'h1);
        check_value("mgmt_gpio_oe_o", 64'(mgmt_gpio_oe), 64'h0);
        check_value("mgmt_gpio_out_o", 64'(mgmt_gpio_out), 64'h0);
        check_value("wb_ack_o", 64'(wb_ack), 64'h0);
        check_value("serial_clock_o", 64'(serial_clock), 64'h0);
        for (int p = 0; p < PADS; p++) begin
            read_expect($sformatf("reset ctrl %0d", p), ctrl_adr(p), 32'(ctrl_model[p]));
        end
        read_expect("reset xfer", XFER_ADR, 32'h0);

        // Register access with random words and byte lane 0 gating
        for (int p = 0; p < PADS; p++) write_ctrl(p, 32'($random(seed)));
        for (int p = 0; p < PADS; p++) begin
            read_expect($sformatf("ctrl %0d", p), ctrl_adr(p), 32'(ctrl_model[p]));
        end
        wb_write(ctrl_adr(PADS - 1), 32'($random(seed)), 4'b1110);
        read_expect("ctrl sel0 clear", ctrl_adr(PADS - 1), 32'(ctrl_model[PADS-1]));
        wb_write(ctrl_adr(0), 32'($random(seed)), 4'b0010);
        read_expect("ctrl sel0 clear", ctrl_adr(0), 32'(ctrl_model[0]));
        read_expect("unmapped 0x10", BASE + 32'h10, 32'h0);
        read_expect("unmapped 0x1c", BASE + 32'h1C, 32'h0);
        expect_no_ack(BASE + 32'h100);
        expect_no_ack(32'h0000_0020);

        // GPIO data in both directions
        mgmt_gpio_in = PADS'({$random(seed), $random(seed)});
        for (int k = 0; k < WORDS; k++) begin
            data = 32'(64'(mgmt_gpio_in) >> (32 * k));   // Pad 32k + j is bit j of word k
            read_expect($sformatf("gpio in word %0d", k), data_adr(k), data);
        end

        // Output data still holds its reset value of zero on enabled pads
        check_value("mgmt_gpio_out_o", 64'(mgmt_gpio_out), 64'h0);
        out_words = '0;
        for (int k = 0; k < WORDS; k++) begin
            data = 32'($random(seed));
            wb_write(data_adr(k), data, 4'hF);
            out_words[32*k +: 32] = data;
        end
        gpio_model = PADS'(out_words);
        check_value("mgmt_gpio_out_o", 64'(mgmt_gpio_out), 64'(gpio_model & inp_dis_bits()));
        check_value("mgmt_gpio_oe_o", 64'(mgmt_gpio_oe), 64'(inp_dis_bits()));

        // OEB bits of pads 0 and 1 reach the core
        write_ctrl(0, 32'({ctrl_model[0][CBITS-1:2], 1'b0, ctrl_model[0][0]}));
        write_ctrl(1, 32'({ctrl_model[1][CBITS-1:2], 1'b1, ctrl_model[1][0]}));
        check_value("jtag_oenb_state_o", 64'(jtag_oenb), 64'h0);
        check_value("sdo_oenb_state_o", 64'(sdo_oenb), 64'h1);
        write_ctrl(0, 32'({ctrl_model[0][CBITS-1:2], 1'b1, ctrl_model[0][0]}));
        write_ctrl(1, 32'({ctrl_model[1][CBITS-1:2], 1'b0, ctrl_model[1][0]}));
        check_value("jtag_oenb_state_o", 64'(jtag_oenb), 64'h1);
        check_value("sdo_oenb_state_o", 64'(sdo_oenb), 64'h0);

        // Two serial loads that each start from fresh random words
        run_load();
        run_load();

        $display("Errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
